/* verification/dcacheStimulus.txt */
# op addr wdata mask expected, op L load, H load that must hit, S store,
# V checks the last write-back (addr of a word in the line, expected word)
L 00001008 0000000000000000 00 00001008ffffeff7
H 00001010 0000000000000000 00 00001010ffffefef
S 00001008 1122334455667788 0f 0000000000000000
H 00001008 0000000000000000 00 0000100855667788
L 00001800 0000000000000000 00 00001800ffffe7ff
L 00002000 0000000000000000 00 00002000ffffdfff
V 00001008 0000000000000000 00 0000100855667788
V 00001018 0000000000000000 00 00001018ffffefe7
L 00001008 0000000000000000 00 0000100855667788
H 00001000 0000000000000000 00 00001000ffffefff
S 00003010 a5a5a5a5deadbeef ff 0000000000000000
H 00003010 0000000000000000 00 a5a5a5a5deadbeef
H 00003018 0000000000000000 00 00003018ffffcfe7

/* sim.f */
source/dcachePkg.sv
source/requestStage.sv
source/cacheController.sv
source/tagStore.sv
source/dataStore.sv
source/memPort.sv
source/dcacheTop.sv
verification/dcacheTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= dcacheTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb import dcachePkg::*; ();

  // op letters in the stimulus file
  localparam int OpLoad    = 32'h4c;  // L
  localparam int OpHitLoad = 32'h48;  // H
  localparam int OpStore   = 32'h53;  // S
  localparam int OpCheckWb = 32'h56;  // V
  localparam int CharHash  = 32'h23;
  localparam int CharNl    = 32'h0a;
  localparam int CharCr    = 32'h0d;
  localparam int CharSpace = 32'h20;
  localparam int CharTab   = 32'h09;

  localparam int ReadyTimeout = 200;
  localparam int DoneTimeout  = 200;
  localparam int RdLatency    = 3;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 reqValid_i;
  logic                 reqWrite_i;
  logic [AddrWidth-1:0] reqAddr_i;
  logic [XLen-1:0]      reqWrData_i;
  logic [MaskWidth-1:0] reqWrMask_i;
  logic                 ready_o;
  logic                 done_o;
  logic [XLen-1:0]      rdData_o;
  logic                 memRdReq_o;
  logic [AddrWidth-1:0] memRdAddr_o;
  logic                 memRdValid_i = 1'b0;
  logic [XLen-1:0]      memRdData_i  = '0;
  logic                 memRdLast_i  = 1'b0;
  logic                 memWrReq_o;
  logic [AddrWidth-1:0] memWrAddr_o;
  logic [LineWidth-1:0] memWrData_o;
  logic                 memWrReady_i = 1'b0;

  // memory model state
  logic [XLen-1:0]      mem [logic [AddrWidth-1:0]];
  logic [31:0]          lfsrState = 32'he7bf;
  int                   rdPhase;
  int                   rdGap;
  logic [1:0]           rdBeat;
  logic [AddrWidth-1:0] rdBase;
  int                   wrPhase;
  logic [1:0]           wrGap;
  logic [AddrWidth-1:0] wbAddr = 32'hffff_ffff;
  logic [LineWidth-1:0] wbLine = '0;
  int                   fd;

  dcacheTop dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    lfsrStep = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // unwritten words hold their own address over its inverse
  function automatic logic [XLen-1:0] readWord(input logic [AddrWidth-1:0] a);
    if (mem.exists(a)) begin
      readWord = mem[a];
    end else begin
      readWord = {a, ~a};
    end
  endfunction

  // read side, a fixed gap then four beats
  always @(posedge clk or negedge rst_n) begin : readModel
    if (!rst_n) begin
      rdPhase      <= 0;
      rdGap        <= 0;
      rdBeat       <= '0;
      rdBase       <= '0;
      memRdValid_i <= 1'b0;
      memRdLast_i  <= 1'b0;
      memRdData_i  <= '0;
    end else begin
      memRdValid_i <= 1'b0;
      memRdLast_i  <= 1'b0;
      if (rdPhase == 0) begin
        if (memRdReq_o) begin
          rdBase  <= memRdAddr_o;
          rdGap   <= RdLatency;
          rdPhase <= 1;
        end
      end else if (rdPhase == 1) begin
        if (rdGap == 0) begin
          rdBeat  <= '0;
          rdPhase <= 2;
        end else begin
          rdGap <= rdGap - 1;
        end
      end else begin
        memRdValid_i <= 1'b1;
        memRdData_i  <= readWord(rdBase + 32'({rdBeat, 3'b000}));
        memRdLast_i  <= (rdBeat == 2'd3);
        rdBeat       <= rdBeat + 2'd1;
        if (rdBeat == 2'd3) begin
          rdPhase <= 0;
        end
      end
    end
  end

  // write side, random 0..3 cycle delay before ready
  always @(posedge clk or negedge rst_n) begin : writeModel
    logic [1:0] delay;
    if (!rst_n) begin
      wrPhase      <= 0;
      wrGap        <= '0;
      memWrReady_i <= 1'b0;
    end else begin
      memWrReady_i <= 1'b0;
      if (wrPhase == 0) begin
        if (memWrReq_o) begin
          for (int i = 0; i < 2; i++) begin
            lfsrState = lfsrStep(lfsrState);
            delay[i]  = lfsrState[0];
          end
          wrGap   <= delay;
          wrPhase <= 1;
        end
      end else if (wrPhase == 1) begin
        if (wrGap == 2'd0) begin
          memWrReady_i <= 1'b1;
          wbAddr = memWrAddr_o;
          wbLine = memWrData_o;
          for (int i = 0; i < BeatsPerLine; i++) begin
            mem[memWrAddr_o + 32'(i * 8)] = memWrData_o[i*XLen +: XLen];
          end
          wrPhase <= 2;
        end else begin
          wrGap <= wrGap - 2'd1;
        end
      end else begin
        wrPhase <= 0;
      end
    end
  end

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      stopOnError($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // skips blanks and comment lines, then reads one entry
  task automatic readEntry(output bit got, output int op, output logic [31:0] addr,
                           output logic [63:0] wdata, output logic [7:0] mask,
                           output logic [63:0] expData);
    int c;
    int n;
    got = 1'b0;
    op  = 0;
    c   = $fgetc(fd);
    while (c == CharSpace || c == CharNl || c == CharCr || c == CharTab || c == CharHash) begin
      if (c == CharHash) begin
        while (c != CharNl && c != -1) begin
          c = $fgetc(fd);
        end
      end
      c = $fgetc(fd);
    end
    if (c != -1) begin
      op = c;
      n  = $fscanf(fd, "%h %h %h %h", addr, wdata, mask, expData);
      if (n != 4) begin
        stopOnError("stimulus file has a line with missing or bad fields");
      end
      got = 1'b1;
    end
  endtask

  task automatic runRequest(input string name, input logic isStore, input logic expectHit,
                            input logic [31:0] addr, input logic [63:0] wdata,
                            input logic [7:0] mask, input logic [63:0] expData);
    int   waitCnt;
    int   latency;
    logic sawRdReq;
    waitCnt = 0;
    @(negedge clk);
    while (!ready_o) begin
      waitCnt++;
      if (waitCnt > ReadyTimeout) begin
        stopOnError($sformatf("timed out waiting for ready_o before %s", name));
      end
      @(negedge clk);
    end
    @(posedge clk);
    reqValid_i  <= 1'b1;
    reqWrite_i  <= isStore;
    reqAddr_i   <= addr;
    reqWrData_i <= wdata;
    reqWrMask_i <= mask;
    // accepted on this edge
    @(posedge clk);
    reqValid_i <= 1'b0;
    @(negedge clk);
    latency  = 1;
    sawRdReq = memRdReq_o;
    while (!done_o) begin
      if (latency > DoneTimeout) begin
        stopOnError($sformatf("timed out waiting for done_o in %s", name));
      end
      @(negedge clk);
      latency++;
      sawRdReq = sawRdReq | memRdReq_o;
    end
    if (!isStore) begin
      checkValue($sformatf("%s load data", name), expData, rdData_o);
    end
    if (expectHit) begin
      // a refill started by the lookup would show one cycle later
      @(negedge clk);
      sawRdReq = sawRdReq | memRdReq_o;
      checkValue($sformatf("%s hit latency", name), 64'd1, 64'(latency));
      checkValue($sformatf("%s read request on hit", name), 64'd0, 64'(sawRdReq));
    end
  endtask

  task automatic checkWriteBack(input string name, input logic [31:0] addr,
                                input logic [63:0] expData);
    logic [1:0] word;
    word = addr[4:3];
    checkValue($sformatf("%s write-back address", name), 64'({addr[31:5], 5'b00000}),
               64'(wbAddr));
    checkValue($sformatf("%s write-back word", name), expData, wbLine[word*XLen +: XLen]);
  endtask

  initial begin : mainFlow
    bit          got;
    int          op;
    int          entry;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  mask;
    logic [63:0] expData;
    string       name;
    rst_n       = 1'b0;
    reqValid_i  = 1'b0;
    reqWrite_i  = 1'b0;
    reqAddr_i   = '0;
    reqWrData_i = '0;
    reqWrMask_i = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("reset ready_o", 64'd1, 64'(ready_o));
    checkValue("reset done_o", 64'd0, 64'(done_o));
    checkValue("reset memRdReq_o", 64'd0, 64'(memRdReq_o));
    checkValue("reset memWrReq_o", 64'd0, 64'(memWrReq_o));

    fd = $fopen("verification/dcacheStimulus.txt", "r");
    if (fd == 0) begin
      stopOnError("could not open verification/dcacheStimulus.txt");
    end
    entry = 0;
    readEntry(got, op, addr, wdata, mask, expData);
    while (got) begin
      entry++;
      name = $sformatf("entry %0d at %h", entry, addr);
      if (op == OpLoad) begin
        runRequest(name, 1'b0, 1'b0, addr, wdata, mask, expData);
      end else if (op == OpHitLoad) begin
        runRequest(name, 1'b0, 1'b1, addr, wdata, mask, expData);
      end else if (op == OpStore) begin
        runRequest(name, 1'b1, 1'b0, addr, wdata, mask, expData);
      end else if (op == OpCheckWb) begin
        checkWriteBack(name, addr, expData);
      end else begin
        stopOnError($sformatf("unknown operation in stimulus %s", name));
      end
      readEntry(got, op, addr, wdata, mask, expData);
    end
    $fclose(fd);
    checkValue("stimulus entries read", 64'd1, 64'(entry > 0));
    $display("All tests passed");
    $finish;
  end

endmodule

/* source/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop import dcachePkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // pipeline side
  input  logic                    reqValid_i,
  input  logic                    reqWrite_i,
  input  logic [AddrWidth-1:0]    reqAddr_i,
  input  logic [XLen-1:0]         reqWrData_i,
  input  logic [MaskWidth-1:0]    reqWrMask_i,
  output logic                    ready_o,
  output logic                    done_o,
  output logic [XLen-1:0]         rdData_o,
  // memory side
  output logic                    memRdReq_o,
  output logic [AddrWidth-1:0]    memRdAddr_o,
  input  logic                    memRdValid_i,
  input  logic [XLen-1:0]         memRdData_i,
  input  logic                    memRdLast_i,
  output logic                    memWrReq_o,
  output logic [AddrWidth-1:0]    memWrAddr_o,
  output logic [LineWidth-1:0]    memWrData_o,
  input  logic                    memWrReady_i
);

  logic [TagWidth-1:0]             tag;
  logic [IndexWidth-1:0]           index;
  logic [$clog2(BeatsPerLine)-1:0] wordSel;
  logic                            isWrite;
  logic [LineWidth-1:0]            lineData;
  logic [LineWidth-1:0]            lineMask;

  logic                            accept;
  logic                            hit;
  logic [NumWays-1:0]              wayHit;
  logic                            victimWay;
  logic                            victimDirty;
  logic [TagWidth-1:0]             victimTag;
  logic [LineWidth-1:0]            victimLine;

  logic                            storeHit;
  logic                            tagUpdate;
  logic                            lineWrite;
  logic                            startWriteBack;
  logic                            startRefill;
  logic                            wbDone;
  logic                            refillDone;
  logic [LineWidth-1:0]            refillLine;

  requestStage uRequestStage (
    .clk         (clk),
    .rst_n       (rst_n),
    .reqValid_i  (reqValid_i),
    .reqWrite_i  (reqWrite_i),
    .reqAddr_i   (reqAddr_i),
    .reqWrData_i (reqWrData_i),
    .reqWrMask_i (reqWrMask_i),
    .accept_i    (accept),
    .tag_o       (tag),
    .index_o     (index),
    .wordSel_o   (wordSel),
    .isWrite_o   (isWrite),
    .lineData_o  (lineData),
    .lineMask_o  (lineMask)
  );

  cacheController uCacheController (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .isWrite_i        (isWrite),
    .hit_i            (hit),
    .victimDirty_i    (victimDirty),
    .wbDone_i         (wbDone),
    .refillDone_i     (refillDone),
    .ready_o          (ready_o),
    .accept_o         (accept),
    .done_o           (done_o),
    .storeHit_o       (storeHit),
    .startWriteBack_o (startWriteBack),
    .startRefill_o    (startRefill),
    .lineWrite_o      (lineWrite),
    .tagUpdate_o      (tagUpdate)
  );

  tagStore uTagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .tag_i         (tag),
    .index_i       (index),
    .storeHit_i    (storeHit),
    .tagUpdate_i   (tagUpdate),
    .hit_o         (hit),
    .wayHit_o      (wayHit),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore uDataStore (
    .clk          (clk),
    .index_i      (index),
    .wayHit_i     (wayHit),
    .victimWay_i  (victimWay),
    .storeHit_i   (storeHit),
    .lineWrite_i  (lineWrite),
    .refillLine_i (refillLine),
    .storeData_i  (lineData),
    .storeMask_i  (lineMask),
    .wordSel_i    (wordSel),
    .rdWord_o     (rdData_o),
    .victimLine_o (victimLine)
  );

  memPort uMemPort (
    .clk              (clk),
    .rst_n            (rst_n),
    .startWriteBack_i (startWriteBack),
    .startRefill_i    (startRefill),
    .tag_i            (tag),
    .index_i          (index),
    .victimTag_i      (victimTag),
    .victimLine_i     (victimLine),
    .memRdValid_i     (memRdValid_i),
    .memRdData_i      (memRdData_i),
    .memRdLast_i      (memRdLast_i),
    .memWrReady_i     (memWrReady_i),
    .wbDone_o         (wbDone),
    .refillDone_o     (refillDone),
    .refillLine_o     (refillLine),
    .memRdReq_o       (memRdReq_o),
    .memRdAddr_o      (memRdAddr_o),
    .memWrReq_o       (memWrReq_o),
    .memWrAddr_o      (memWrAddr_o),
    .memWrData_o      (memWrData_o)
  );

endmodule

/* source/memPort.sv */
`timescale 1ns/1ps

module memPort import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  startWriteBack_i,
  input  logic                  startRefill_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [TagWidth-1:0]   victimTag_i,
  input  logic [LineWidth-1:0]  victimLine_i,
  input  logic                  memRdValid_i,
  input  logic [XLen-1:0]       memRdData_i,
  input  logic                  memRdLast_i,
  input  logic                  memWrReady_i,
  output logic                  wbDone_o,
  output logic                  refillDone_o,
  output logic [LineWidth-1:0]  refillLine_o,
  output logic                  memRdReq_o,
  output logic [AddrWidth-1:0]  memRdAddr_o,
  output logic                  memWrReq_o,
  output logic [AddrWidth-1:0]  memWrAddr_o,
  output logic [LineWidth-1:0]  memWrData_o
);

  logic [$clog2(BeatsPerLine)-1:0] beatCnt;
  logic                            rdActive;
  logic                            beatTaken;

  assign beatTaken   = rdActive & memRdValid_i;
  assign memRdAddr_o = {tag_i, index_i, {OffsetWidth{1'b0}}};

  // write burst, one 256-bit transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memWrReq_o <= 1'b0;
      wbDone_o   <= 1'b0;
    end else begin
      wbDone_o <= memWrReq_o & memWrReady_i;
      if (startWriteBack_i) begin
        memWrReq_o <= 1'b1;
      end else if (memWrReady_i) begin
        memWrReq_o <= 1'b0;
      end
    end
  end

  // victim address and line held for the whole write
  always_ff @(posedge clk) begin
    if (startWriteBack_i) begin
      memWrAddr_o <= {victimTag_i, index_i, {OffsetWidth{1'b0}}};
      memWrData_o <= victimLine_i;
    end
  end

  // read burst, low word arrives first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdReq_o   <= 1'b0;
      rdActive     <= 1'b0;
      beatCnt      <= '0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= beatTaken & memRdLast_i;
      if (startRefill_i) begin
        memRdReq_o <= 1'b1;
        rdActive   <= 1'b1;
        beatCnt    <= '0;
      end else begin
        if (memRdValid_i) begin
          memRdReq_o <= 1'b0;
        end
        if (beatTaken) begin
          beatCnt <= beatCnt + 1'b1;
          if (memRdLast_i) begin
            rdActive <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beatTaken) begin
      refillLine_o[beatCnt*XLen +: XLen] <= memRdData_i;
    end
  end

endmodule

/* source/dataStore.sv */
`timescale 1ns/1ps

module dataStore import dcachePkg::*; (
  input  logic                            clk,
  input  logic [IndexWidth-1:0]           index_i,
  input  logic [NumWays-1:0]              wayHit_i,
  input  logic                            victimWay_i,
  input  logic                            storeHit_i,
  input  logic                            lineWrite_i,
  input  logic [LineWidth-1:0]            refillLine_i,
  input  logic [LineWidth-1:0]            storeData_i,
  input  logic [LineWidth-1:0]            storeMask_i,
  input  logic [$clog2(BeatsPerLine)-1:0] wordSel_i,
  output logic [XLen-1:0]                 rdWord_o,
  output logic [LineWidth-1:0]            victimLine_o
);

  logic [LineWidth-1:0] lines [NumWays][NumSets];
  logic [LineWidth-1:0] hitLine;

  // wayHit is one-hot or zero, so an or-merge selects the line
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (wayHit_i[w]) begin
        hitLine = hitLine | lines[w][index_i];
      end
    end
  end

  assign rdWord_o     = hitLine[wordSel_i*XLen +: XLen];
  assign victimLine_o = lines[victimWay_i][index_i];

  always_ff @(posedge clk) begin
    for (int w = 0; w < NumWays; w++) begin
      if (lineWrite_i && (victimWay_i == 1'(w))) begin
        lines[w][index_i] <= refillLine_i;
      end else if (storeHit_i && wayHit_i[w]) begin
        // keep unmasked bytes of the old line
        lines[w][index_i] <= (lines[w][index_i] & ~storeMask_i) | (storeData_i & storeMask_i);
      end
    end
  end

endmodule

/* source/tagStore.sv */
`timescale 1ns/1ps

module tagStore import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic [IndexWidth-1:0] index_i,
  input  logic                  storeHit_i,
  input  logic                  tagUpdate_i,
  output logic                  hit_o,
  output logic [NumWays-1:0]    wayHit_o,
  output logic                  victimWay_o,
  output logic                  victimDirty_o,
  output logic [TagWidth-1:0]   victimTag_o
);

  logic [TagWidth-1:0] tagArr   [NumWays][NumSets];
  logic [NumSets-1:0]  validArr [NumWays];
  logic [NumSets-1:0]  dirtyArr [NumWays];
  logic                victimBit;

  always_comb begin
    for (int w = 0; w < NumWays; w++) begin
      wayHit_o[w] = validArr[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign hit_o = |wayHit_o;

  // one global bit picks the way to replace
  assign victimWay_o   = victimBit;
  assign victimTag_o   = tagArr[victimBit][index_i];
  assign victimDirty_o = validArr[victimBit][index_i] & dirtyArr[victimBit][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < NumWays; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
      victimBit <= 1'b0;
    end else begin
      for (int w = 0; w < NumWays; w++) begin
        if (tagUpdate_i && (victimBit == 1'(w))) begin
          // freshly refilled line is clean
          validArr[w][index_i] <= 1'b1;
          dirtyArr[w][index_i] <= 1'b0;
        end else if (storeHit_i && wayHit_o[w]) begin
          dirtyArr[w][index_i] <= 1'b1;
        end
      end
      if (tagUpdate_i) begin
        victimBit <= ~victimBit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tagUpdate_i) begin
      tagArr[victimBit][index_i] <= tag_i;
    end
  end

endmodule

/* source/cacheController.sv */
`timescale 1ns/1ps

module cacheController import dcachePkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic reqValid_i,
  input  logic isWrite_i,
  input  logic hit_i,
  input  logic victimDirty_i,
  input  logic wbDone_i,
  input  logic refillDone_i,
  output logic ready_o,
  output logic accept_o,
  output logic done_o,
  output logic storeHit_o,
  output logic startWriteBack_o,
  output logic startRefill_o,
  output logic lineWrite_o,
  output logic tagUpdate_o
);

  cacheState_e state;
  cacheState_e nextState;
  logic        inCompare;
  logic        miss;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      Idle: begin
        if (reqValid_i) begin
          nextState = Compare;
        end
      end
      Compare: begin
        if (hit_i) begin
          nextState = Idle;
        end else if (victimDirty_i) begin
          nextState = WriteBack;
        end else begin
          nextState = Refill;
        end
      end
      // wait for memory to take the dirty line
      WriteBack: begin
        if (wbDone_i) begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (refillDone_i) begin
          nextState = Replace;
        end
      end
      // line and tag written here, then look up again
      Replace: begin
        nextState = Compare;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  assign inCompare = (state == Compare);
  assign miss      = inCompare & ~hit_i;

  assign ready_o  = (state == Idle);
  assign accept_o = ready_o & reqValid_i;

  // every request ends with a hit in compare
  assign done_o     = inCompare & hit_i;
  assign storeHit_o = done_o & isWrite_i;

  assign startWriteBack_o = miss & victimDirty_i;
  assign startRefill_o    = (miss & ~victimDirty_i) | ((state == WriteBack) & wbDone_i);

  assign lineWrite_o = (state == Replace);
  assign tagUpdate_o = (state == Replace);

endmodule

/* source/requestStage.sv */
`timescale 1ns/1ps

module requestStage import dcachePkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reqValid_i,
  input  logic                            reqWrite_i,
  input  logic [AddrWidth-1:0]            reqAddr_i,
  input  logic [XLen-1:0]                 reqWrData_i,
  input  logic [MaskWidth-1:0]            reqWrMask_i,
  input  logic                            accept_i,
  output logic [TagWidth-1:0]             tag_o,
  output logic [IndexWidth-1:0]           index_o,
  output logic [$clog2(BeatsPerLine)-1:0] wordSel_o,
  output logic                            isWrite_o,
  output logic [LineWidth-1:0]            lineData_o,
  output logic [LineWidth-1:0]            lineMask_o
);

  logic [AddrWidth-1:0] addrQ;
  logic [XLen-1:0]      dataQ;
  logic [MaskWidth-1:0] maskQ;
  logic [XLen-1:0]      bitMask;
  logic                 capture;

  assign capture = reqValid_i & accept_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addrQ     <= '0;
      isWrite_o <= 1'b0;
    end else if (capture) begin
      addrQ     <= reqAddr_i;
      isWrite_o <= reqWrite_i;
    end
  end

  // store payload only
  always_ff @(posedge clk) begin
    if (capture) begin
      dataQ <= reqWrData_i;
      maskQ <= reqWrMask_i;
    end
  end

  // address split into tag, set index and word within the line
  assign tag_o     = addrQ[AddrWidth-1 -: TagWidth];
  assign index_o   = addrQ[OffsetWidth +: IndexWidth];
  assign wordSel_o = addrQ[OffsetWidth-1 -: $clog2(BeatsPerLine)];

  // byte enables widened to one bit per data bit
  always_comb begin
    for (int b = 0; b < MaskWidth; b++) begin
      bitMask[b*8 +: 8] = {8{maskQ[b]}};
    end
  end

  // move word and mask into the selected lane of the line
  assign lineData_o = LineWidth'(dataQ) << (wordSel_o * XLen);
  assign lineMask_o = LineWidth'(bitMask) << (wordSel_o * XLen);

endmodule

/* source/dcachePkg.sv */
package dcachePkg;

  // address and data widths
  localparam int AddrWidth = 32;
  localparam int XLen      = 64;
  localparam int MaskWidth = XLen / 8;

  // line geometry
  localparam int LineWidth    = 256;
  localparam int BeatsPerLine = LineWidth / XLen;

  // address fields, tag | index | offset
  localparam int OffsetWidth = 5;
  localparam int IndexWidth  = 6;
  localparam int TagWidth    = AddrWidth - IndexWidth - OffsetWidth;

  localparam int NumSets = 1 << IndexWidth;
  localparam int NumWays = 2;

  // controller states
  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    Refill,
    Replace
  } cacheState_e;

endpackage
